/* common/cnnMemPkg.sv */
package cnnMemPkg;

  // host address bits 15:14 pick the buffer
  typedef enum logic [1:0] {
    regWeights,
    regEdges,
    regInput,
    regOutput
  } regionE;

  typedef struct packed {
    regionE      region;
    logic [11:0] wordOffset;
    logic [1:0]  byteSel;    // host accesses are full words so this is not decoded
  } hostAddrT;

  localparam int kBits      = 16;
  localparam int edgeBits   = 24;
  localparam int yBits      = 32;
  localparam int xBits      = 8;
  localparam int inWideBits = 64;

  localparam int weightsDepth     = 256;
  localparam int edgesDepth       = 64;
  localparam int outputDepth      = 128;
  localparam int inputNarrowDepth = 512;

  localparam int weightsLatency = 3;
  localparam int edgesLatency   = 1;
  localparam int outputLatency  = 2;

  typedef struct packed {
    logic        isWrite;
    hostAddrT    addr;
    logic [31:0] wdata;
  } memReqT;

  typedef struct packed {
    logic [31:0] rdata;
    logic        slvErr;
  } memRspT;

  // the engine sees eight pixels, the host sees two 32-bit words
  typedef union packed {
    logic [7:0][7:0]  lanes;
    logic [1:0][31:0] halves;
  } inWordU;

  typedef struct packed {
    logic        rdEn;
    logic [5:0]  rdAddr;
    logic        wrEn;
    logic [6:0]  wrAddr;
    logic [31:0] wrData;
  } engPortT;

endpackage

/* src/latencyRam.sv */
module latencyRam #(
  parameter int DEPTH   = 256,
  parameter int WIDTH   = 16,
  parameter int LATENCY = 3
) (
  input  logic                     clkA,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         di,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] pipe [LATENCY];

  // stage 0 is the registered read, later stages only move while en is held
  always_ff @(posedge clkA) begin
    if (en) begin
      if (we) begin
        mem[addr] <= di;
        pipe[0]   <= di;   // write-first
      end else begin
        pipe[0] <= mem[addr];
      end
      for (int i = 1; i < LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign dout = pipe[LATENCY-1];

endmodule

/* src/asymRamReadWider.sv */
module asymRamReadWider #(
  parameter int NARROW      = 8,
  parameter int WIDE        = 64,
  parameter int NARROWDEPTH = 512
) (
  input  logic                                       clkA,
  input  logic                                       wrEn,
  input  logic [$clog2(NARROWDEPTH)-1:0]             wrAddr,
  input  logic [NARROW-1:0]                          wrData,
  input  logic                                       rdEn,
  input  logic [$clog2(NARROWDEPTH*NARROW/WIDE)-1:0] rdAddr,
  output cnnMemPkg::inWordU                          rdData
);

  localparam int ratio     = WIDE / NARROW;
  localparam int laneBits  = $clog2(ratio);
  localparam int wideDepth = NARROWDEPTH / ratio;
  localparam int addrBits  = $clog2(NARROWDEPTH);

  logic [ratio-1:0][NARROW-1:0] mem [wideDepth];
  logic [ratio-1:0]             laneEn;
  logic [addrBits-laneBits-1:0] wordAddr;

  // the low address bits pick the lane inside the wide word
  always_comb begin
    laneEn   = '0;
    wordAddr = wrAddr[addrBits-1:laneBits];
    if (wrEn) begin
      laneEn = ratio'(1) << wrAddr[laneBits-1:0];
    end
  end

  always_ff @(posedge clkA) begin
    for (int i = 0; i < ratio; i++) begin
      if (laneEn[i]) begin
        mem[wordAddr][i] <= wrData;   // other lanes keep their pixels
      end
    end
    if (rdEn) begin
      rdData.lanes <= mem[rdAddr];
    end
  end

endmodule

/* hostBridge/axiLiteFrontEnd.sv */
module axiLiteFrontEnd (
  input  logic              clkA,
  input  logic              reset,
  input  logic              awvalid,
  output logic              awready,
  input  logic [15:0]       awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [31:0]       wdata,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [15:0]       araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              reqValid,
  output cnnMemPkg::memReqT req,
  input  logic              reqGrant,
  input  logic              rspValid,
  input  cnnMemPkg::memRspT rsp
);

  typedef enum logic [2:0] {
    stIdle,
    stCollect,
    stRequest,
    stWait,
    stRespond
  } stateE;

  stateE      state;
  logic       haveAw;
  logic       haveW;
  logic [1:0] respCode;
  logic       awFire;
  logic       wFire;
  logic       arFire;

  // a pending read wins only while no write half has been taken
  assign arready = (state == stCollect) && !haveAw && !haveW;
  assign awready = (state == stCollect) && !haveAw && (haveW || !arvalid);
  assign wready  = (state == stCollect) && !haveW && (haveAw || !arvalid);

  assign awFire = awvalid && awready;
  assign wFire  = wvalid && wready;
  assign arFire = arvalid && arready;

  assign reqValid = (state == stRequest);
  assign bvalid   = (state == stRespond) && req.isWrite;
  assign rvalid   = (state == stRespond) && !req.isWrite;
  assign bresp    = respCode;
  assign rresp    = respCode;

  always_ff @(posedge clkA) begin
    if (reset) begin
      state  <= stIdle;
      haveAw <= 1'b0;
      haveW  <= 1'b0;
    end else begin
      case (state)
        stIdle: state <= stCollect;
        stCollect: begin
          if (arFire) begin
            state <= stRequest;
          end else if ((awFire || haveAw) && (wFire || haveW)) begin
            state  <= stRequest;
            haveAw <= 1'b0;
            haveW  <= 1'b0;
          end else begin
            haveAw <= haveAw || awFire;
            haveW  <= haveW || wFire;
          end
        end
        stRequest: if (reqGrant) state <= stWait;
        stWait: if (rspValid) state <= stRespond;
        stRespond: if ((bvalid && bready) || (rvalid && rready)) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clkA) begin
    if (arFire) begin
      req.isWrite <= 1'b0;
      req.addr    <= cnnMemPkg::hostAddrT'(araddr);
      req.wdata   <= '0;
    end else begin
      if (awFire) begin
        req.isWrite <= 1'b1;
        req.addr    <= cnnMemPkg::hostAddrT'(awaddr);
      end
      if (wFire) req.wdata <= wdata;
    end
    if (state == stWait && rspValid) begin
      respCode <= rsp.slvErr ? 2'b10 : 2'b00;
      rdata    <= rsp.slvErr ? 32'h0 : rsp.rdata;
    end
  end

endmodule

/* hostBridge/memRequestRouter.sv */
module memRequestRouter #(
  parameter int kBits            = 16,
  parameter int edgeBits         = 24,
  parameter int yBits            = 32,
  parameter int xBits            = 8,
  parameter int inWideBits       = 64,
  parameter int weightsDepth     = 256,
  parameter int edgesDepth       = 64,
  parameter int outputDepth      = 128,
  parameter int inputNarrowDepth = 512,
  parameter int weightsLatency   = 3,
  parameter int edgesLatency     = 1,
  parameter int outputLatency    = 2
) (
  input  logic                                clkA,
  input  logic                                reset,
  input  logic                                reqValid,
  input  cnnMemPkg::memReqT                   req,
  output logic                                reqGrant,
  output logic                                rspValid,
  output cnnMemPkg::memRspT                   rsp,
  input  cnnMemPkg::engPortT                  eng,
  output logic                                wEn,
  output logic                                wWe,
  output logic [$clog2(weightsDepth)-1:0]     wAddr,
  output logic [kBits-1:0]                    wDi,
  input  logic [kBits-1:0]                    wDout,
  output logic                                eEn,
  output logic                                eWe,
  output logic [$clog2(edgesDepth)-1:0]       eAddr,
  output logic [edgeBits-1:0]                 eDi,
  input  logic [edgeBits-1:0]                 eDout,
  output logic                                oEn,
  output logic                                oWe,
  output logic [$clog2(outputDepth)-1:0]      oAddr,
  output logic [yBits-1:0]                    oDi,
  input  logic [yBits-1:0]                    oDout,
  output logic                                iWrEn,
  output logic [$clog2(inputNarrowDepth)-1:0] iWrAddr,
  output logic [xBits-1:0]                    iWrData,
  output logic                                iRdEn,
  output logic [$clog2(inputNarrowDepth*xBits/inWideBits)-1:0] iRdAddr,
  input  cnnMemPkg::inWordU                   iRdData
);

  localparam int inAddrBits = $clog2(inputNarrowDepth);
  localparam int laneBits   = $clog2(inWideBits / xBits);

  cnnMemPkg::regionE region;
  cnnMemPkg::regionE pendRegion;
  logic [11:0]       offset;
  logic              inRange;
  logic              conflict;
  logic [3:0]        regionLat;
  logic [3:0]        cnt;
  logic              pending;
  logic              pendErr;
  logic              pendWrite;
  logic              pendHalf;
  logic              hit;
  logic              hold;

  assign region = req.addr.region;
  assign offset = req.addr.wordOffset;

  always_comb begin
    inRange   = 1'b0;
    conflict  = 1'b0;
    regionLat = 4'd1;
    case (region)
      cnnMemPkg::regWeights: begin
        inRange   = int'(offset) < weightsDepth;
        regionLat = 4'(weightsLatency);
      end
      cnnMemPkg::regEdges: begin
        inRange   = int'(offset) < edgesDepth;
        regionLat = 4'(edgesLatency);
      end
      cnnMemPkg::regInput: begin
        inRange  = int'(offset) < inputNarrowDepth;
        conflict = !req.isWrite && eng.rdEn;   // engine owns the read port this cycle
      end
      default: begin
        inRange   = int'(offset) < outputDepth;
        conflict  = eng.wrEn;
        regionLat = 4'(outputLatency);
      end
    endcase
  end

  assign reqGrant = reqValid && !pending && !conflict;
  assign hit      = reqGrant && inRange;
  assign hold     = pending && (cnt != 4'd0);   // keeps the RAM pipeline moving
  assign rspValid = pending && (cnt == 4'd0);

  assign wEn   = (hit && region == cnnMemPkg::regWeights) ||
                 (hold && pendRegion == cnnMemPkg::regWeights);
  assign wWe   = hit && req.isWrite;
  assign wAddr = offset[$clog2(weightsDepth)-1:0];
  assign wDi   = req.wdata[kBits-1:0];

  assign eEn   = (hit && region == cnnMemPkg::regEdges) ||
                 (hold && pendRegion == cnnMemPkg::regEdges);
  assign eWe   = hit && req.isWrite;
  assign eAddr = offset[$clog2(edgesDepth)-1:0];
  assign eDi   = req.wdata[edgeBits-1:0];

  // engine writes take the output port whenever they show up
  assign oEn   = eng.wrEn || (hit && region == cnnMemPkg::regOutput) ||
                 (hold && pendRegion == cnnMemPkg::regOutput);
  assign oWe   = eng.wrEn || (hit && region == cnnMemPkg::regOutput && req.isWrite);
  assign oAddr = eng.wrEn ? eng.wrAddr : offset[$clog2(outputDepth)-1:0];
  assign oDi   = eng.wrEn ? eng.wrData : req.wdata[yBits-1:0];

  assign iWrEn   = hit && region == cnnMemPkg::regInput && req.isWrite;
  assign iWrAddr = offset[inAddrBits-1:0];
  assign iWrData = req.wdata[xBits-1:0];
  assign iRdEn   = eng.rdEn || (hit && region == cnnMemPkg::regInput && !req.isWrite);
  assign iRdAddr = eng.rdEn ? eng.rdAddr : offset[inAddrBits-1:laneBits];

  always_ff @(posedge clkA) begin
    if (reset) begin
      pending <= 1'b0;
      cnt     <= 4'd0;
    end else if (reqGrant) begin
      pending <= 1'b1;
      cnt     <= (req.isWrite || !inRange) ? 4'd0 : regionLat - 4'd1;
    end else if (pending) begin
      if (cnt == 4'd0) pending <= 1'b0;
      else cnt <= cnt - 4'd1;
    end
  end

  always_ff @(posedge clkA) begin
    if (reqGrant) begin
      pendRegion <= region;
      pendErr    <= !inRange;
      pendWrite  <= req.isWrite;
      pendHalf   <= offset[laneBits-1];   // upper four lanes sit in the upper half
    end
  end

  always_comb begin
    rsp.rdata  = '0;
    rsp.slvErr = pendErr;
    if (!pendErr && !pendWrite) begin
      case (pendRegion)
        cnnMemPkg::regWeights: rsp.rdata[kBits-1:0] = wDout;
        cnnMemPkg::regEdges:   rsp.rdata[edgeBits-1:0] = eDout;
        cnnMemPkg::regInput:   rsp.rdata = iRdData.halves[pendHalf];
        default:               rsp.rdata[yBits-1:0] = oDout;
      endcase
    end
  end

endmodule

/* src/cnnMemTop.sv */
module cnnMemTop #(
  parameter int kBits            = cnnMemPkg::kBits,
  parameter int edgeBits         = cnnMemPkg::edgeBits,
  parameter int yBits            = cnnMemPkg::yBits,
  parameter int xBits            = cnnMemPkg::xBits,
  parameter int inWideBits       = cnnMemPkg::inWideBits,
  parameter int weightsDepth     = cnnMemPkg::weightsDepth,
  parameter int edgesDepth       = cnnMemPkg::edgesDepth,
  parameter int outputDepth      = cnnMemPkg::outputDepth,
  parameter int inputNarrowDepth = cnnMemPkg::inputNarrowDepth,
  parameter int weightsLatency   = cnnMemPkg::weightsLatency,
  parameter int edgesLatency     = cnnMemPkg::edgesLatency,
  parameter int outputLatency    = cnnMemPkg::outputLatency
) (
  input  logic               clkA,
  input  logic               reset,
  input  logic               awvalid,
  output logic               awready,
  input  logic [15:0]        awaddr,
  input  logic               wvalid,
  output logic               wready,
  input  logic [31:0]        wdata,
  output logic               bvalid,
  input  logic               bready,
  output logic [1:0]         bresp,
  input  logic               arvalid,
  output logic               arready,
  input  logic [15:0]        araddr,
  output logic               rvalid,
  input  logic               rready,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  input  cnnMemPkg::engPortT eng,
  output logic [63:0]        engRdData
);

  localparam int inAddrBits = $clog2(inputNarrowDepth);
  localparam int inRdBits   = $clog2(inputNarrowDepth * xBits / inWideBits);

  logic reqValid, reqGrant, rspValid;
  cnnMemPkg::memReqT req;
  cnnMemPkg::memRspT rsp;

  logic wEn, wWe, eEn, eWe, oEn, oWe, iWrEn, iRdEn;
  logic [$clog2(weightsDepth)-1:0] wAddr;
  logic [$clog2(edgesDepth)-1:0]   eAddr;
  logic [$clog2(outputDepth)-1:0]  oAddr;
  logic [kBits-1:0]    wDi, wDout;
  logic [edgeBits-1:0] eDi, eDout;
  logic [yBits-1:0]    oDi, oDout;
  logic [inAddrBits-1:0] iWrAddr;
  logic [xBits-1:0]      iWrData;
  logic [inRdBits-1:0]   iRdAddr;
  cnnMemPkg::inWordU     iRdData;

  assign engRdData = iRdData;   // engine and host share the input read port

  axiLiteFrontEnd frontEnd (.*);

  memRequestRouter #(
    .kBits(kBits), .edgeBits(edgeBits), .yBits(yBits), .xBits(xBits),
    .inWideBits(inWideBits), .weightsDepth(weightsDepth), .edgesDepth(edgesDepth),
    .outputDepth(outputDepth), .inputNarrowDepth(inputNarrowDepth),
    .weightsLatency(weightsLatency), .edgesLatency(edgesLatency),
    .outputLatency(outputLatency)
  ) router (.*);

  latencyRam #(.DEPTH(weightsDepth), .WIDTH(kBits), .LATENCY(weightsLatency)) weightBuf (
    .clkA(clkA), .en(wEn), .we(wWe), .addr(wAddr), .di(wDi), .dout(wDout)
  );

  latencyRam #(.DEPTH(edgesDepth), .WIDTH(edgeBits), .LATENCY(edgesLatency)) edgeBuf (
    .clkA(clkA), .en(eEn), .we(eWe), .addr(eAddr), .di(eDi), .dout(eDout)
  );

  latencyRam #(.DEPTH(outputDepth), .WIDTH(yBits), .LATENCY(outputLatency)) outputBuf (
    .clkA(clkA), .en(oEn), .we(oWe), .addr(oAddr), .di(oDi), .dout(oDout)
  );

  asymRamReadWider #(.NARROW(xBits), .WIDE(inWideBits), .NARROWDEPTH(inputNarrowDepth))
  inputBuf (
    .clkA(clkA), .wrEn(iWrEn), .wrAddr(iWrAddr), .wrData(iWrData),
    .rdEn(iRdEn), .rdAddr(iRdAddr), .rdData(iRdData)
  );

endmodule

/* verif/cnnMemTb.sv */
module cnnMemTb;

  localparam int timeoutCycles = 200;
  localparam int busyEngAddr   = 20;    // engine target while a host output read waits
  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  typedef enum logic [2:0] {opHostWr, opHostRd, opEngWr, opEngRd, opBusyRd} opE;

  typedef struct {
    opE                 op;
    cnnMemPkg::regionE  region;
    int                 offset;     // word index for engine reads
    logic [1:0]         expResp;
    int                 hold;       // cycles with bready or rready held low
  } stepT;

  logic               clkA;
  logic               reset;
  logic               awvalid;
  logic               awready;
  logic [15:0]        awaddr;
  logic               wvalid;
  logic               wready;
  logic [31:0]        wdata;
  logic               bvalid;
  logic               bready;
  logic [1:0]         bresp;
  logic               arvalid;
  logic               arready;
  logic [15:0]        araddr;
  logic               rvalid;
  logic               rready;
  logic [31:0]        rdata;
  logic [1:0]         rresp;
  cnnMemPkg::engPortT eng;
  logic [63:0]        engRdData;

  // reference copies of the four buffers
  logic [15:0] weightsRef [256];
  logic [23:0] edgesRef [64];
  logic [7:0]  inputRef [512];
  logic [31:0] outputRef [128];

  stepT        steps[$];
  logic [31:0] lfsr;
  int          valueErrors;
  int          timeouts;

  cnnMemTop uut (.*);

  initial clkA = 1'b0;
  always #2 clkA = ~clkA;

  // Galois LFSR stepped once for each bit taken
  function automatic logic [31:0] nextRandom(input int nBits);
    logic [31:0] value;
    logic        bitOut;
    value = '0;
    for (int i = 0; i < nBits; i++) begin
      bitOut = lfsr[0];
      lfsr   = lfsr >> 1;
      if (bitOut) lfsr = lfsr ^ 32'hD000_0001;
      value = {value[30:0], bitOut};
    end
    return value;
  endfunction

  function automatic logic [15:0] hostAddr(input cnnMemPkg::regionE region, input int offset);
    return {region, offset[11:0], 2'b00};
  endfunction

  function automatic void modelWrite(input cnnMemPkg::regionE region, input int offset,
                                     input logic [31:0] data);
    case (region)
      cnnMemPkg::regWeights: weightsRef[offset[7:0]] = data[15:0];
      cnnMemPkg::regEdges:   edgesRef[offset[5:0]] = data[23:0];
      cnnMemPkg::regInput:   inputRef[offset[8:0]] = data[7:0];   // one pixel per write
      default:               outputRef[offset[6:0]] = data;
    endcase
  endfunction

  function automatic logic [31:0] modelRead(input cnnMemPkg::regionE region, input int offset);
    logic [8:0] base;
    base = offset[8:0] & 9'h1FC;   // four pixels that share one half word
    case (region)
      cnnMemPkg::regWeights: return {16'h0, weightsRef[offset[7:0]]};
      cnnMemPkg::regEdges:   return {8'h0, edgesRef[offset[5:0]]};
      cnnMemPkg::regInput: begin
        return {inputRef[base + 9'd3], inputRef[base + 9'd2],
                inputRef[base + 9'd1], inputRef[base]};
      end
      default:               return outputRef[offset[6:0]];
    endcase
  endfunction

  function automatic logic [63:0] modelWord(input int word);
    logic [63:0] value;
    logic [8:0]  base;
    value = '0;
    base  = 9'(word * 8);
    for (int i = 7; i >= 0; i--) begin
      value = {value[55:0], inputRef[base + 9'(i)]};   // lane 7 ends up on top
    end
    return value;
  endfunction

  function automatic void addStep(input opE op, input cnnMemPkg::regionE region,
                                  input int offset, input logic [1:0] expResp = 2'b00,
                                  input int hold = 0);
    stepT s;
    s.op      = op;
    s.region  = region;
    s.offset  = offset;
    s.expResp = expResp;
    s.hold    = hold;
    steps.push_back(s);
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic reportTimeout(input string what);
    timeouts++;
    $display("timeout at %0t after %0d cycles: %s", $time, timeoutCycles, what);
  endtask

  task automatic takeResponse(input logic isWrite, input int hold, input logic [1:0] expResp,
                              input logic [31:0] expData);
    int          waited;
    string       chan;
    logic [1:0]  heldResp;
    logic [31:0] heldData;
    chan   = isWrite ? "b" : "r";
    waited = 0;
    @(negedge clkA);
    while (!(isWrite ? bvalid : rvalid) && waited < timeoutCycles) begin
      @(negedge clkA);
      waited++;
    end
    if (!(isWrite ? bvalid : rvalid)) begin
      reportTimeout({chan, "valid never came"});
      return;
    end
    heldResp = isWrite ? bresp : rresp;
    heldData = rdata;
    for (int i = 0; i < hold; i++) begin
      @(negedge clkA);
      checkValue({chan, "valid"}, 64'd1, 64'(isWrite ? bvalid : rvalid));
      checkValue({chan, "resp"}, 64'(heldResp), 64'(isWrite ? bresp : rresp));
      if (!isWrite) checkValue("rdata", 64'(heldData), 64'(rdata));
      checkValue("awready", 64'd0, 64'(awready));   // nothing new while busy
      checkValue("wready", 64'd0, 64'(wready));
      checkValue("arready", 64'd0, 64'(arready));
    end
    @(posedge clkA);
    #1;
    bready = isWrite;
    rready = !isWrite;
    @(negedge clkA);
    checkValue({chan, "valid"}, 64'd1, 64'(isWrite ? bvalid : rvalid));
    checkValue({chan, "resp"}, 64'(expResp), 64'(isWrite ? bresp : rresp));
    if (!isWrite) checkValue("rdata", 64'(expData), 64'(rdata));
    @(posedge clkA);
    #1;
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic hostWrite(input cnnMemPkg::regionE region, input int offset,
                           input logic [31:0] data, input logic [1:0] expResp, input int hold);
    int   waited;
    logic awTaken;
    logic wTaken;
    @(posedge clkA);
    #1;
    awaddr  = hostAddr(region, offset);
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    waited  = 0;
    while ((awvalid || wvalid) && waited < timeoutCycles) begin
      @(negedge clkA);
      awTaken = awvalid && awready;
      wTaken  = wvalid && wready;
      @(posedge clkA);
      #1;
      if (awTaken) awvalid = 1'b0;
      if (wTaken) wvalid = 1'b0;
      waited++;
    end
    if (awvalid || wvalid) begin
      awvalid = 1'b0;
      wvalid  = 1'b0;
      reportTimeout("write address or data was never accepted");
    end else begin
      takeResponse(1'b1, hold, expResp, 32'h0);
    end
  endtask

  task automatic hostRead(input cnnMemPkg::regionE region, input int offset,
                          input logic [1:0] expResp, input int hold);
    int          waited;
    logic        taken;
    logic [31:0] expData;
    expData = (expResp == respOkay) ? modelRead(region, offset) : 32'h0;
    @(posedge clkA);
    #1;
    araddr  = hostAddr(region, offset);
    arvalid = 1'b1;
    taken   = 1'b0;
    waited  = 0;
    while (!taken && waited < timeoutCycles) begin
      @(negedge clkA);
      taken = arready;
      @(posedge clkA);
      #1;
      waited++;
    end
    arvalid = 1'b0;
    if (!taken) reportTimeout("read address was never accepted");
    else takeResponse(1'b0, hold, expResp, expData);
  endtask

  // back-to-back engine writes on consecutive cycles
  task automatic engineWrites(input int addr, input int count);
    logic [31:0] data;
    @(posedge clkA);
    #1;
    for (int i = 0; i < count; i++) begin
      data           = nextRandom(32);
      eng.wrEn       = 1'b1;
      eng.wrAddr     = addr[6:0];
      eng.wrData     = data;
      outputRef[addr[6:0]] = data;
      @(posedge clkA);
      #1;
    end
    eng.wrEn = 1'b0;
  endtask

  task automatic engineRead(input int word);
    @(posedge clkA);
    #1;
    eng.rdEn   = 1'b1;
    eng.rdAddr = word[5:0];
    @(posedge clkA);
    #1;
    eng.rdEn = 1'b0;
    checkValue("engRdData", modelWord(word), engRdData);
  endtask

  function automatic void buildTable();
    addStep(opHostWr, cnnMemPkg::regWeights, 5);
    addStep(opHostWr, cnnMemPkg::regWeights, 200);
    addStep(opHostWr, cnnMemPkg::regWeights, 255);
    addStep(opHostWr, cnnMemPkg::regEdges, 0);
    addStep(opHostWr, cnnMemPkg::regEdges, 63);
    addStep(opHostRd, cnnMemPkg::regWeights, 5);
    addStep(opHostRd, cnnMemPkg::regWeights, 200);
    addStep(opHostRd, cnnMemPkg::regWeights, 255);
    addStep(opHostRd, cnnMemPkg::regEdges, 0);
    addStep(opHostRd, cnnMemPkg::regEdges, 63);
    for (int i = 0; i < 8; i++) addStep(opHostWr, cnnMemPkg::regInput, 24 + i);
    addStep(opEngRd, cnnMemPkg::regInput, 3);
    addStep(opHostWr, cnnMemPkg::regInput, 26);
    addStep(opEngRd, cnnMemPkg::regInput, 3);
    addStep(opHostRd, cnnMemPkg::regInput, 24);
    addStep(opHostRd, cnnMemPkg::regInput, 29);
    addStep(opHostRd, cnnMemPkg::regInput, 26);
    for (int i = 504; i < 512; i++) addStep(opHostWr, cnnMemPkg::regInput, i);
    addStep(opEngRd, cnnMemPkg::regInput, 63);
    addStep(opHostRd, cnnMemPkg::regInput, 508);
    addStep(opEngWr, cnnMemPkg::regOutput, 10);
    addStep(opEngWr, cnnMemPkg::regOutput, 11);
    addStep(opHostRd, cnnMemPkg::regOutput, 10);
    addStep(opHostRd, cnnMemPkg::regOutput, 11);
    addStep(opHostWr, cnnMemPkg::regOutput, 50);
    addStep(opHostRd, cnnMemPkg::regOutput, 50);
    addStep(opBusyRd, cnnMemPkg::regOutput, 10);
    addStep(opHostRd, cnnMemPkg::regOutput, busyEngAddr);
    // out-of-range offsets alias onto written words if the range check fails
    addStep(opHostWr, cnnMemPkg::regWeights, 261, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regWeights, 4095, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regWeights, 5);
    addStep(opHostWr, cnnMemPkg::regEdges, 127, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regEdges, 100, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regEdges, 63);
    addStep(opHostWr, cnnMemPkg::regInput, 536, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regInput, 600, respSlvErr);
    addStep(opEngRd, cnnMemPkg::regInput, 3);
    addStep(opHostWr, cnnMemPkg::regOutput, 138, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regOutput, 200, respSlvErr);
    addStep(opHostRd, cnnMemPkg::regOutput, 10);
    addStep(opHostWr, cnnMemPkg::regEdges, 0, respOkay, 5);
    addStep(opHostRd, cnnMemPkg::regEdges, 0, respOkay, 6);
    addStep(opHostRd, cnnMemPkg::regWeights, 200, respOkay, 3);
  endfunction

  initial begin
    logic [31:0] data;
    lfsr        = 32'he5ab_c415;
    valueErrors = 0;
    timeouts    = 0;
    reset       = 1'b1;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    eng         = '0;
    buildTable();
    repeat (16) @(posedge clkA);
    #1;
    reset = 1'b0;
    for (int i = 0; i < steps.size() && timeouts == 0; i++) begin
      case (steps[i].op)
        opHostWr: begin
          data = nextRandom(32);
          hostWrite(steps[i].region, steps[i].offset, data, steps[i].expResp, steps[i].hold);
          if (steps[i].expResp == respOkay) modelWrite(steps[i].region, steps[i].offset, data);
        end
        opHostRd: hostRead(steps[i].region, steps[i].offset, steps[i].expResp, steps[i].hold);
        opEngWr:  engineWrites(steps[i].offset, 1);
        opEngRd:  engineRead(steps[i].offset);
        default: begin
          fork
            hostRead(steps[i].region, steps[i].offset, respOkay, 0);
            engineWrites(busyEngAddr, 8);
          join
        end
      endcase
    end
    repeat (4) @(posedge clkA);
    $display("checks done with %0d value errors and %0d timeouts", valueErrors, timeouts);
    if (valueErrors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
common/cnnMemPkg.sv
src/latencyRam.sv
src/asymRamReadWider.sv
hostBridge/axiLiteFrontEnd.sv
hostBridge/memRequestRouter.sv
src/cnnMemTop.sv
verif/cnnMemTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# builds and runs the buffer subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module cnnMemTb -o cnnMemSim
./obj_dir/cnnMemSim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
